// File: fetch_settings.svh
/* fetch stage 1 settings
   lane count, widths, table sizes and the reset PC */
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// lanes per fetch bundle
`define FETCH_WIDTH     2

// address and instruction widths
`define PC_WIDTH        32
`define INST_WIDTH      32
`define INST_BYTES      4

// predictor table sizes as index widths
`define BTB_INDEX_BITS  4
`define BP_INDEX_BITS   6
`define RAS_PTR_BITS    3

// first fetch address out of reset
`define RESET_PC        32'h0000_1000

`endif

// File: hw/fetchPkg.sv
/* fetch stage 1 types
   control kinds, predictor packets and the per-lane output bundle */
`include "fetch_settings.svh"

package fetchPkg;

    // control kind, cond branch is the all-ones code
    typedef enum logic [1:0] {
        CALL        = 2'b00,
        RETURN      = 2'b01,
        JUMP        = 2'b10,
        COND_BRANCH = 2'b11
    } ctrlType_e;

    // one lane's BTB lookup
    typedef struct packed {
        logic                   hit;
        ctrlType_e              ctrlType;
        logic [`PC_WIDTH-1:0]   takenPc;
    } btbPkt_t;

    // retired control instruction, arrives in program order
    typedef struct packed {
        logic                   en;
        logic [`PC_WIDTH-1:0]   pc;
        logic [`PC_WIDTH-1:0]   npc;
        ctrlType_e              brType;
        logic                   dir;
        // counter as read when the branch was predicted
        logic [1:0]             counter;
    } updatePkt_t;

    typedef struct packed {
        logic                   flag;
        logic [`PC_WIDTH-1:0]   pc;
    } redirectPkt_t;

    // one lane towards fetch stage 2
    typedef struct packed {
        logic                   valid;
        logic [`PC_WIDTH-1:0]   pc;
        logic [`INST_WIDTH-1:0] inst;
        logic                   btbHit;
        ctrlType_e              ctrlType;
        logic [`PC_WIDTH-1:0]   takenPc;
        logic                   predDir;
        logic [1:0]             predCounter;
    } fetchLane_t;

    typedef fetchLane_t [`FETCH_WIDTH-1:0] fetchBundle_t;
    typedef logic [`FETCH_WIDTH-1:0][`INST_WIDTH-1:0] instBundle_t;
    typedef logic [`FETCH_WIDTH-1:0][`PC_WIDTH-1:0] lanePcs_t;

endpackage

// File: hw/branchTargetBuffer.sv
/* branch target buffer
   direct-mapped tagged target table, one lookup per lane and one training port */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module branchTargetBuffer (
    input  logic                                  clk,
    input  logic                                  reset,
    input  fetchPkg::lanePcs_t                    lanePc_i,
    input  fetchPkg::updatePkt_t                  update_i,
    output fetchPkg::btbPkt_t [`FETCH_WIDTH-1:0]  btb_o
);
    import fetchPkg::*;

    localparam int OFFSET_BITS = $clog2(`INST_BYTES);
    localparam int ENTRIES     = 1 << `BTB_INDEX_BITS;
    localparam int TAG_BITS    = `PC_WIDTH - OFFSET_BITS - `BTB_INDEX_BITS;

    // per-entry state
    logic [ENTRIES-1:0]          entryValid;
    logic [TAG_BITS-1:0]         entryTag    [ENTRIES];
    ctrlType_e                   entryType   [ENTRIES];
    logic [`PC_WIDTH-1:0]        entryTarget [ENTRIES];

    logic [`BTB_INDEX_BITS-1:0]  updIndex;
    logic [TAG_BITS-1:0]         updTag;
    logic                        updWrite;

    // index sits right above the instruction offset
    assign updIndex = update_i.pc[OFFSET_BITS +: `BTB_INDEX_BITS];
    assign updTag   = update_i.pc[`PC_WIDTH-1 -: TAG_BITS];
    // only taken control instructions allocate
    assign updWrite = update_i.en & update_i.dir;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            entryValid  <= '0;
            entryTag    <= '{default: '0};
            entryType   <= '{default: CALL};
            entryTarget <= '{default: '0};
        end
        else if (updWrite)
        begin
            // new entry replaces whatever sat at this index
            entryValid[updIndex]  <= 1'b1;
            entryTag[updIndex]    <= updTag;
            entryType[updIndex]   <= update_i.brType;
            entryTarget[updIndex] <= update_i.npc;
        end
    end

    // lookup, one compare per lane
    always_comb
    begin
        logic [`BTB_INDEX_BITS-1:0] idx;
        logic [TAG_BITS-1:0]        tag;
        for (int i = 0; i < `FETCH_WIDTH; i++)
        begin
            idx               = lanePc_i[i][OFFSET_BITS +: `BTB_INDEX_BITS];
            tag               = lanePc_i[i][`PC_WIDTH-1 -: TAG_BITS];
            btb_o[i].hit      = entryValid[idx] && (entryTag[idx] == tag);
            btb_o[i].ctrlType = entryType[idx];
            btb_o[i].takenPc  = entryTarget[idx];
        end
    end

endmodule

// File: hw/bimodalPredictor.sv
/* bimodal direction predictor
   table of 2-bit saturating counters, one read per lane */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module bimodalPredictor (
    input  logic                               clk,
    input  logic                               reset,
    input  fetchPkg::lanePcs_t                 lanePc_i,
    input  fetchPkg::updatePkt_t               update_i,
    output logic [`FETCH_WIDTH-1:0]            predDir_o,
    output logic [`FETCH_WIDTH-1:0][1:0]       predCounter_o
);
    import fetchPkg::*;

    localparam int OFFSET_BITS = $clog2(`INST_BYTES);
    localparam int ENTRIES     = 1 << `BP_INDEX_BITS;

    logic [1:0]                 counterTable [ENTRIES];
    logic [`BP_INDEX_BITS-1:0]  updIndex;
    logic                       updWrite;
    logic [1:0]                 nextCounter;

    assign updIndex = update_i.pc[OFFSET_BITS +: `BP_INDEX_BITS];
    // jumps, calls and returns never touch the counters
    assign updWrite = update_i.en & (update_i.brType == COND_BRANCH);

    // saturate at both ends, starting from the counter seen at predict time
    always_comb
    begin
        if (update_i.dir)
            nextCounter = (update_i.counter == 2'd3) ? 2'd3 : update_i.counter + 2'd1;
        else
            nextCounter = (update_i.counter == 2'd0) ? 2'd0 : update_i.counter - 2'd1;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            // weakly not taken
            counterTable <= '{default: 2'b01};
        end
        else if (updWrite)
        begin
            counterTable[updIndex] <= nextCounter;
        end
    end

    // upper counter bit is the direction
    always_comb
    begin
        for (int i = 0; i < `FETCH_WIDTH; i++)
        begin
            predCounter_o[i] = counterTable[lanePc_i[i][OFFSET_BITS +: `BP_INDEX_BITS]];
            predDir_o[i]     = predCounter_o[i][1];
        end
    end

endmodule

// File: hw/returnAddressStack.sv
/* return address stack
   circular stack of call return addresses, top read combinationally */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module returnAddressStack (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   pushEn_i,
    input  logic                   popEn_i,
    input  logic [`PC_WIDTH-1:0]   pushAddr_i,
    output logic [`PC_WIDTH-1:0]   rasTop_o
);

    localparam int DEPTH = 1 << `RAS_PTR_BITS;

    logic [`PC_WIDTH-1:0]      stack [DEPTH];
    // points at the current top entry
    logic [`RAS_PTR_BITS-1:0]  topPtr;
    logic [`RAS_PTR_BITS-1:0]  pushPtr;

    // pointer wraps, so overflow overwrites the oldest return address
    assign pushPtr = topPtr + `RAS_PTR_BITS'(1);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            topPtr <= '0;
            stack  <= '{default: '0};
        end
        else if (pushEn_i)
        begin
            stack[pushPtr] <= pushAddr_i;
            topPtr         <= pushPtr;
        end
        else if (popEn_i)
        begin
            // entry stays in place, only the pointer retreats
            topPtr <= topPtr - `RAS_PTR_BITS'(1);
        end
    end

    assign rasTop_o = stack[topPtr];

endmodule

// File: hw/nextPcSelect.sv
/* next PC selection
   first taken lane picks the predicted PC, redirects and stall take priority */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module nextPcSelect (
    input  logic [`PC_WIDTH-1:0]                  pc_i,
    input  logic [`FETCH_WIDTH-1:0]               laneValid_i,
    input  fetchPkg::btbPkt_t [`FETCH_WIDTH-1:0]  btb_i,
    input  logic [`FETCH_WIDTH-1:0]               predDir_i,
    input  logic [`PC_WIDTH-1:0]                  rasTop_i,
    input  fetchPkg::redirectPkt_t                recover_i,
    input  fetchPkg::redirectPkt_t                fs2Recover_i,
    input  logic                                  stall_i,
    output logic [`PC_WIDTH-1:0]                  nextPc_o,
    output logic [`PC_WIDTH-1:0]                  pushAddr_o,
    output logic                                  pushEn_o,
    output logic                                  popEn_o
);
    import fetchPkg::*;

    localparam int CNT_BITS = $clog2(`FETCH_WIDTH + 1);

    logic [`FETCH_WIDTH-1:0]  takenVec;
    logic [CNT_BITS-1:0]      numValid;
    logic [`PC_WIDTH-1:0]     predPc;
    logic                     predPush;
    logic                     predPop;

    // taken lane is a valid BTB hit that is not a not-taken cond branch
    always_comb
    begin
        for (int i = 0; i < `FETCH_WIDTH; i++)
        begin
            takenVec[i] = laneValid_i[i] & btb_i[i].hit
                        & ((btb_i[i].ctrlType != COND_BRANCH) | predDir_i[i]);
        end
    end

    always_comb
    begin
        logic found;
        found    = 1'b0;
        numValid = '0;
        for (int i = 0; i < `FETCH_WIDTH; i++)
            numValid = numValid + CNT_BITS'(laneValid_i[i]);
        // fall through past every valid lane, zero valid lanes keeps pc
        predPc     = pc_i + `PC_WIDTH'(numValid) * `PC_WIDTH'(`INST_BYTES);
        predPush   = 1'b0;
        predPop    = 1'b0;
        pushAddr_o = pc_i + `PC_WIDTH'(`INST_BYTES);
        // lowest taken lane wins
        for (int i = 0; i < `FETCH_WIDTH; i++)
        begin
            if (takenVec[i] && !found)
            begin
                found = 1'b1;
                if (btb_i[i].ctrlType == RETURN)
                begin
                    predPc  = rasTop_i;
                    predPop = 1'b1;
                end
                else
                begin
                    predPc = btb_i[i].takenPc;
                    // return lands right after the call
                    predPush   = (btb_i[i].ctrlType == CALL);
                    pushAddr_o = pc_i + `PC_WIDTH'((i + 1) * `INST_BYTES);
                end
            end
        end
    end

    // back end first, then fs2, then the prediction unless stalled
    always_comb
    begin
        pushEn_o = 1'b0;
        popEn_o  = 1'b0;
        if (recover_i.flag)
            nextPc_o = recover_i.pc;
        else if (fs2Recover_i.flag)
            nextPc_o = fs2Recover_i.pc;
        else if (!stall_i)
        begin
            nextPc_o = predPc;
            pushEn_o = predPush;
            popEn_o  = predPop;
        end
        else
            nextPc_o = pc_i;
    end

endmodule

// File: hw/fetchStage1.sv
/* fetch stage 1
   PC register and fetch request, BTB, bimodal and RAS prediction, lane bundle out */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetchStage1 (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    instValid_i,
    input  fetchPkg::instBundle_t   inst_i,
    input  logic                    stall_i,
    input  fetchPkg::redirectPkt_t  recover_i,
    input  fetchPkg::redirectPkt_t  fs2Recover_i,
    input  fetchPkg::updatePkt_t    update_i,
    output logic                    fetchReq_o,
    output fetchPkg::lanePcs_t      lanePc_o,
    output fetchPkg::fetchBundle_t  bundle_o,
    output logic                    fs1Ready_o,
    output logic [`PC_WIDTH-1:0]    addrRas_o
);
    import fetchPkg::*;

    logic [`PC_WIDTH-1:0]          pc;
    logic [`PC_WIDTH-1:0]          nextPc;
    lanePcs_t                      lanePc;
    logic [`FETCH_WIDTH-1:0]       laneValid;
    btbPkt_t [`FETCH_WIDTH-1:0]    btbPkt;
    logic [`FETCH_WIDTH-1:0]       predDir;
    logic [`FETCH_WIDTH-1:0][1:0]  predCounter;
    logic                          pushEn;
    logic                          popEn;
    logic [`PC_WIDTH-1:0]          pushAddr;
    logic [`PC_WIDTH-1:0]          rasTop;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            pc         <= `RESET_PC;
            fetchReq_o <= 1'b0;
        end
        else
        begin
            pc         <= nextPc;
            // requests start on the first edge out of reset
            fetchReq_o <= 1'b1;
        end
    end

    // consecutive instructions from the bundle base
    always_comb
    begin
        for (int i = 0; i < `FETCH_WIDTH; i++)
            lanePc[i] = pc + `PC_WIDTH'(i * `INST_BYTES);
    end

    // one valid bit from the source covers the whole bundle
    assign laneValid = {`FETCH_WIDTH{instValid_i & fetchReq_o}};

    branchTargetBuffer btb (
        .clk        (clk),
        .reset      (reset),
        .lanePc_i   (lanePc),
        .update_i   (update_i),
        .btb_o      (btbPkt)
    );

    bimodalPredictor bp (
        .clk            (clk),
        .reset          (reset),
        .lanePc_i       (lanePc),
        .update_i       (update_i),
        .predDir_o      (predDir),
        .predCounter_o  (predCounter)
    );

    returnAddressStack ras (
        .clk         (clk),
        .reset       (reset),
        .pushEn_i    (pushEn),
        .popEn_i     (popEn),
        .pushAddr_i  (pushAddr),
        .rasTop_o    (rasTop)
    );

    nextPcSelect npc (
        .pc_i          (pc),
        .laneValid_i   (laneValid),
        .btb_i         (btbPkt),
        .predDir_i     (predDir),
        .rasTop_i      (rasTop),
        .recover_i     (recover_i),
        .fs2Recover_i  (fs2Recover_i),
        .stall_i       (stall_i),
        .nextPc_o      (nextPc),
        .pushAddr_o    (pushAddr),
        .pushEn_o      (pushEn),
        .popEn_o       (popEn)
    );

    // per-lane packets towards fs2
    always_comb
    begin
        for (int i = 0; i < `FETCH_WIDTH; i++)
        begin
            bundle_o[i].valid       = laneValid[i];
            bundle_o[i].pc          = lanePc[i];
            bundle_o[i].inst        = laneValid[i] ? inst_i[i] : '0;
            bundle_o[i].btbHit      = btbPkt[i].hit;
            bundle_o[i].ctrlType    = btbPkt[i].ctrlType;
            // returns take their target from the stack top
            bundle_o[i].takenPc     = (btbPkt[i].ctrlType == RETURN) ? rasTop : btbPkt[i].takenPc;
            bundle_o[i].predDir     = predDir[i];
            bundle_o[i].predCounter = predCounter[i];
        end
    end

    assign lanePc_o   = lanePc;
    assign fs1Ready_o = laneValid[0];
    assign addrRas_o  = rasTop;

endmodule

// File: tests/fetchStage1_properties.sv
/* fetch stage 1 properties
   reset, stack action and recover checks bound into the top level */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetchStage1Props (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    fetchReq_i,
    input  logic                    pushEn_i,
    input  logic                    popEn_i,
    input  fetchPkg::redirectPkt_t  recover_i,
    input  logic [`PC_WIDTH-1:0]    pc_i
);

    // no requests while in reset
    reqInReset: assert property (@(posedge clk) reset |-> !fetchReq_i)
        else $error("fetch request raised during reset");

    // one stack action per cycle
    pushPopExclusive: assert property (@(posedge clk) disable iff (reset)
        !(pushEn_i && popEn_i))
        else $error("push and pop in the same cycle");

    // back end redirect lands on the next edge
    recoverSetsPc: assert property (@(posedge clk) disable iff (reset)
        recover_i.flag |=> pc_i == $past(recover_i.pc))
        else $error("pc does not follow recover");

endmodule

bind fetchStage1 fetchStage1Props props (
    .clk         (clk),
    .reset       (reset),
    .fetchReq_i  (fetchReq_o),
    .pushEn_i    (pushEn),
    .popEn_i     (popEn),
    .recover_i   (recover_i),
    .pc_i        (pc)
);

// File: tests/fetchStage1Tb.sv
/* fetch stage 1 testbench
   reference model of PC, BTB, counters and RAS checked against the DUT every cycle */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetchStage1Tb;
    import fetchPkg::*;

    localparam int TEST_CYCLES = 160;

    // expected result of one cycle
    typedef struct packed {
        logic [`PC_WIDTH-1:0]  nextPc;
        logic                  push;
        logic                  pop;
        logic [`PC_WIDTH-1:0]  pushAddr;
        fetchBundle_t          bundle;
    } expect_t;

    logic          clk;
    logic          reset;
    logic          instValid;
    instBundle_t   inst;
    logic          stall;
    redirectPkt_t  recover;
    redirectPkt_t  fs2Recover;
    updatePkt_t    update;
    logic          fetchReq;
    lanePcs_t      lanePc;
    fetchBundle_t  bundle;
    logic          fs1Ready;
    logic [`PC_WIDTH-1:0] addrRas;

    // model state
    logic [`PC_WIDTH-1:0]  mPc;
    logic                  mReq;
    logic                  mBtbValid [16];
    logic [25:0]           mBtbTag   [16];
    ctrlType_e             mBtbType  [16];
    logic [`PC_WIDTH-1:0]  mBtbTgt   [16];
    logic [1:0]            mCnt      [64];
    logic [`PC_WIDTH-1:0]  mRas      [8];
    logic [2:0]            mPtr;

    logic [31:0]  lcgState = 32'd94;
    int           errCount = 0;
    int           testsRun = 0;
    int           testsFailed = 0;

    fetchStage1 dut (
        .clk           (clk),
        .reset         (reset),
        .instValid_i   (instValid),
        .inst_i        (inst),
        .stall_i       (stall),
        .recover_i     (recover),
        .fs2Recover_i  (fs2Recover),
        .update_i      (update),
        .fetchReq_o    (fetchReq),
        .lanePc_o      (lanePc),
        .bundle_o      (bundle),
        .fs1Ready_o    (fs1Ready),
        .addrRas_o     (addrRas)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    function automatic redirectPkt_t mkRedirect(logic [`PC_WIDTH-1:0] pc);
        redirectPkt_t r;
        r.flag = 1'b1;
        r.pc   = pc;
        return r;
    endfunction

    function automatic updatePkt_t mkUpdate(logic [31:0] pc, logic [31:0] npc,
                                            ctrlType_e kind, logic dir, logic [1:0] cnt);
        updatePkt_t u;
        u.en      = 1'b1;
        u.pc      = pc;
        u.npc     = npc;
        u.brType  = kind;
        u.dir     = dir;
        u.counter = cnt;
        return u;
    endfunction

    // expected bundle, next PC and stack action from the model state
    function automatic expect_t refStep(logic [31:0] pc, logic req, logic valid,
                                        instBundle_t ins, redirectPkt_t rec,
                                        redirectPkt_t fs2, logic stl);
        expect_t      e;
        logic         lv;
        logic         found;
        logic         taken;
        logic [31:0]  lpc;
        logic [3:0]   bi;
        logic [5:0]   ci;
        logic [31:0]  pred;
        logic         push;
        logic         pop;
        lv    = valid & req;
        found = 1'b0;
        push  = 1'b0;
        pop   = 1'b0;
        pred  = lv ? pc + 32'd8 : pc;
        e.pushAddr = pc + 32'd4;
        for (int i = 0; i < 2; i++)
        begin
            lpc = pc + 32'(i * 4);
            bi  = lpc[5:2];
            ci  = lpc[7:2];
            e.bundle[i].valid       = lv;
            e.bundle[i].pc          = lpc;
            e.bundle[i].inst        = lv ? ins[i] : 32'h0;
            e.bundle[i].btbHit      = mBtbValid[bi] && (mBtbTag[bi] == lpc[31:6]);
            e.bundle[i].ctrlType    = mBtbType[bi];
            e.bundle[i].takenPc     = (mBtbType[bi] == RETURN) ? mRas[mPtr] : mBtbTgt[bi];
            e.bundle[i].predDir     = mCnt[ci][1];
            e.bundle[i].predCounter = mCnt[ci];
            taken = lv && e.bundle[i].btbHit
                    && (mBtbType[bi] != COND_BRANCH || mCnt[ci][1]);
            if (taken && !found)
            begin
                found = 1'b1;
                pred  = e.bundle[i].takenPc;
                pop   = (mBtbType[bi] == RETURN);
                push  = (mBtbType[bi] == CALL);
                if (push)
                    e.pushAddr = lpc + 32'd4;
            end
        end
        e.push = 1'b0;
        e.pop  = 1'b0;
        if (rec.flag)
            e.nextPc = rec.pc;
        else if (fs2.flag)
            e.nextPc = fs2.pc;
        else if (!stl)
        begin
            e.nextPc = pred;
            e.push   = push;
            e.pop    = pop;
        end
        else
            e.nextPc = pc;
        return e;
    endfunction

    task automatic checkVal(string name, logic [127:0] got, logic [127:0] exp);
        if (got !== exp)
        begin
            $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
            errCount++;
        end
    endtask

    task automatic resetModel();
        mPc  = `RESET_PC;
        mReq = 1'b0;
        mPtr = 3'd0;
        for (int i = 0; i < 16; i++)
        begin
            mBtbValid[i] = 1'b0;
            mBtbTag[i]   = '0;
            mBtbType[i]  = CALL;
            mBtbTgt[i]   = '0;
        end
        for (int i = 0; i < 64; i++)
            mCnt[i] = 2'd1;
        for (int i = 0; i < 8; i++)
            mRas[i] = '0;
    endtask

    // compare at the falling edge and advance the model at the rising edge
    initial
    begin
        expect_t  pend;
        logic     havePend;
        havePend = 1'b0;
        resetModel();
        forever
        begin
            @(negedge clk);
            havePend = 1'b0;
            if (!reset)
            begin
                pend = refStep(mPc, mReq, instValid, inst, recover, fs2Recover, stall);
                havePend = 1'b1;
                checkVal("lanePc_o[0]", 128'(lanePc[0]), 128'(mPc));
                checkVal("lanePc_o[1]", 128'(lanePc[1]), 128'(mPc + 32'd4));
                checkVal("bundle_o[0]", 128'(bundle[0]), 128'(pend.bundle[0]));
                checkVal("bundle_o[1]", 128'(bundle[1]), 128'(pend.bundle[1]));
                checkVal("fs1Ready_o", 128'(fs1Ready), 128'(pend.bundle[0].valid));
                checkVal("fetchReq_o", 128'(fetchReq), 128'(mReq));
                checkVal("addrRas_o", 128'(addrRas), 128'(mRas[mPtr]));
            end
            @(posedge clk);
            if (reset)
                resetModel();
            else if (havePend)
            begin
                mPc  = pend.nextPc;
                mReq = 1'b1;
                if (pend.push)
                begin
                    mPtr       = mPtr + 3'd1;
                    mRas[mPtr] = pend.pushAddr;
                end
                else if (pend.pop)
                    mPtr = mPtr - 3'd1;
                if (update.en && update.dir)
                begin
                    mBtbValid[update.pc[5:2]] = 1'b1;
                    mBtbTag[update.pc[5:2]]   = update.pc[31:6];
                    mBtbType[update.pc[5:2]]  = update.brType;
                    mBtbTgt[update.pc[5:2]]   = update.npc;
                end
                // saturating counter training
                if (update.en && update.brType == COND_BRANCH)
                begin
                    if (update.dir)
                        mCnt[update.pc[7:2]] = (update.counter == 2'd3) ? 2'd3
                                               : update.counter + 2'd1;
                    else
                        mCnt[update.pc[7:2]] = (update.counter == 2'd0) ? 2'd0
                                               : update.counter - 2'd1;
                end
            end
        end
    end

    // drive one cycle of inputs 1 ns after the edge
    task automatic drive(logic valid, logic stl, redirectPkt_t rec,
                         redirectPkt_t fs2, updatePkt_t upd);
        @(posedge clk);
        #1;
        // new instructions only when the bundle moves on
        if (valid && !stl)
        begin
            inst[0] = nextRand();
            inst[1] = nextRand();
        end
        instValid  = valid;
        stall      = stl;
        recover    = rec;
        fs2Recover = fs2;
        update     = upd;
    endtask

    task automatic report(string name, int errBefore);
        testsRun++;
        if (errCount != errBefore)
        begin
            testsFailed++;
            $display("test %s: failed with %0d errors", name, errCount - errBefore);
        end
        else
            $display("test %s: ok", name);
    endtask

    task automatic seqTest();
        int            e0;
        logic [31:0]   expPc;
        fetchBundle_t  held;
        e0    = errCount;
        expPc = `RESET_PC;
        drive(1'b0, 1'b0, '0, '0, '0);
        repeat (4)
        begin
            drive(1'b1, 1'b0, '0, '0, '0);
            #3;
            checkVal("lanePc_o[0]", 128'(lanePc[0]), 128'(expPc));
            expPc = expPc + 32'd8;
        end
        repeat (2)
        begin
            drive(1'b0, 1'b0, '0, '0, '0);
            #3;
            checkVal("lanePc_o[0]", 128'(lanePc[0]), 128'(expPc));
        end
        drive(1'b1, 1'b1, '0, '0, '0);
        #3;
        held = bundle;
        repeat (2)
        begin
            drive(1'b1, 1'b1, '0, '0, '0);
            #3;
            checkVal("lanePc_o[0]", 128'(lanePc[0]), 128'(expPc));
            checkVal("bundle_o[0]", 128'(bundle[0]), 128'(held[0]));
            checkVal("bundle_o[1]", 128'(bundle[1]), 128'(held[1]));
        end
        drive(1'b0, 1'b0, '0, '0, '0);
        report("sequential", e0);
    endtask

    task automatic jumpTest();
        int e0;
        e0 = errCount;
        drive(1'b0, 1'b0, mkRedirect(32'h2000), '0,
              mkUpdate(32'h2004, 32'h3000, JUMP, 1'b1, 2'd0));
        drive(1'b1, 1'b0, '0, '0, '0);
        #3;
        checkVal("bundle_o[1].btbHit", 128'(bundle[1].btbHit), 128'(1));
        checkVal("bundle_o[1].ctrlType", 128'(bundle[1].ctrlType), 128'(JUMP));
        drive(1'b0, 1'b0, '0, '0, '0);
        #3;
        checkVal("lanePc_o[0]", 128'(lanePc[0]), 128'(32'h3000));
        report("jump", e0);
    endtask

    task automatic trainCond(logic dir, logic [1:0] cnt);
        drive(1'b0, 1'b0, '0, '0, mkUpdate(32'h4000, 32'h5000, COND_BRANCH, dir, cnt));
    endtask

    task automatic probeCond(logic [1:0] expCnt);
        drive(1'b0, 1'b0, mkRedirect(32'h4000), '0, '0);
        drive(1'b1, 1'b0, '0, '0, '0);
        #3;
        checkVal("bundle_o[0].predCounter", 128'(bundle[0].predCounter), 128'(expCnt));
        checkVal("bundle_o[0].predDir", 128'(bundle[0].predDir), 128'(expCnt[1]));
        drive(1'b0, 1'b0, '0, '0, '0);
        #3;
        checkVal("lanePc_o[0]", 128'(lanePc[0]),
                 128'(expCnt[1] ? 32'h5000 : 32'h4008));
    endtask

    task automatic condTest();
        int e0;
        e0 = errCount;
        // installs the entry and leaves the counter at 1
        trainCond(1'b1, 2'd0);
        probeCond(2'd1);
        trainCond(1'b0, 2'd1);
        probeCond(2'd0);
        // not taken at 0 stays at 0
        trainCond(1'b0, 2'd0);
        probeCond(2'd0);
        trainCond(1'b1, 2'd0);
        probeCond(2'd1);
        trainCond(1'b1, 2'd1);
        probeCond(2'd2);
        trainCond(1'b1, 2'd2);
        probeCond(2'd3);
        // taken at 3 stays at 3
        trainCond(1'b1, 2'd3);
        probeCond(2'd3);
        report("conditional", e0);
    endtask

    task automatic callReturnTest();
        int e0;
        e0 = errCount;
        drive(1'b0, 1'b0, '0, '0, mkUpdate(32'h6000, 32'h7000, CALL, 1'b1, 2'd0));
        drive(1'b0, 1'b0, mkRedirect(32'h6000), '0,
              mkUpdate(32'h7004, 32'h0, RETURN, 1'b1, 2'd0));
        drive(1'b1, 1'b0, '0, '0, '0);
        drive(1'b1, 1'b0, '0, '0, '0);
        #3;
        checkVal("lanePc_o[0]", 128'(lanePc[0]), 128'(32'h7000));
        checkVal("addrRas_o", 128'(addrRas), 128'(32'h6004));
        checkVal("bundle_o[1].ctrlType", 128'(bundle[1].ctrlType), 128'(RETURN));
        checkVal("bundle_o[1].takenPc", 128'(bundle[1].takenPc), 128'(32'h6004));
        drive(1'b0, 1'b0, '0, '0, '0);
        #3;
        checkVal("lanePc_o[0]", 128'(lanePc[0]), 128'(32'h6004));
        // stack was empty before the call
        checkVal("addrRas_o", 128'(addrRas), 128'(32'h0));
        report("call and return", e0);
    endtask

    task automatic redirectTest();
        int            e0;
        logic [31:0]   r;
        redirectPkt_t  rec;
        redirectPkt_t  fs2;
        logic          stl;
        logic          haveExp;
        logic [31:0]   expPc;
        e0      = errCount;
        haveExp = 1'b0;
        expPc   = '0;
        for (int n = 0; n < 20; n++)
        begin
            r        = nextRand();
            rec.flag = r[16];
            rec.pc   = 32'h8000 + {20'h0, r[11:3], 3'b000};
            fs2.flag = r[17];
            fs2.pc   = 32'hA000 + {20'h0, r[27:19], 3'b000};
            stl      = r[18];
            drive(r[19], stl, rec, fs2, '0);
            #3;
            if (haveExp)
                checkVal("lanePc_o[0]", 128'(lanePc[0]), 128'(expPc));
            haveExp = rec.flag | fs2.flag | stl;
            expPc   = rec.flag ? rec.pc : (fs2.flag ? fs2.pc : mPc);
        end
        drive(1'b0, 1'b0, '0, '0, '0);
        #3;
        if (haveExp)
            checkVal("lanePc_o[0]", 128'(lanePc[0]), 128'(expPc));
        report("redirect priority", e0);
    endtask

    initial
    begin
        reset      = 1'b1;
        instValid  = 1'b0;
        inst       = '0;
        stall      = 1'b0;
        recover    = '0;
        fs2Recover = '0;
        update     = '0;
        repeat (5) @(posedge clk);
        #1;
        if (fetchReq !== 1'b0 || lanePc[0] !== `RESET_PC)
        begin
            $display("ERROR fetchReq_o %h lanePc_o[0] %h during reset", fetchReq, lanePc[0]);
            errCount++;
        end
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        seqTest();
        jumpTest();
        condTest();
        callReturnTest();
        redirectTest();
        $display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, errCount);
        if (errCount == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    // watchdog
    initial
    begin
        #((TEST_CYCLES + 100) * 10);
        $display("timeout, the tests did not finish in time");
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: sim.f
+incdir+.
hw/fetchPkg.sv
hw/branchTargetBuffer.sv
hw/bimodalPredictor.sv
hw/returnAddressStack.sv
hw/nextPcSelect.sv
hw/fetchStage1.sv
tests/fetchStage1_properties.sv
tests/fetchStage1Tb.sv

// File: Makefile
# Verilator build and run for fetch stage 1

VERILATOR ?= verilator
TOP       ?= fetchStage1Tb
BUILD_DIR ?= obj_dir
FILELIST  ?= sim.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(BUILD_DIR)
